// File: hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

//////////////////////////////////////////////////
// Load and store primary opcodes
//////////////////////////////////////////////////

`define EXE_LB   6'b100000
`define EXE_LH   6'b100001
`define EXE_LW   6'b100011
`define EXE_LBU  6'b100100
`define EXE_LHU  6'b100101

`define EXE_SB   6'b101000
`define EXE_SH   6'b101001
`define EXE_SW   6'b101011

//////////////////////////////////////////////////
// CP0 exception codes
//////////////////////////////////////////////////

`define EXC_ADEL 5'd4   // Address error on load
`define EXC_ADES 5'd5   // Address error on store

//////////////////////////////////////////////////
// Data RAM geometry
//////////////////////////////////////////////////

`define RAM_AW    8
`define RAM_DEPTH (1 << `RAM_AW)

`endif

// File: hdl/mips_pkg.sv
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    typedef logic [3:0]  byte_en_t;  // One bit per byte lane
    typedef logic [5:0]  opcode_t;   // instr[31:26]
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  exccode_t;

    // Word index into data RAM
    typedef logic [`RAM_AW-1:0] ram_addr_t;

    // Width of a memory access
    typedef enum logic [1:0] {
        acc_none,
        acc_byte,
        acc_half,
        acc_word
    } access_e;

endpackage

`default_nettype wire

// File: hdl/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mem_ctrl (
    input  mips_pkg::word_t    instr,
    input  mips_pkg::word_t    addr,
    input  mips_pkg::word_t    store_data,
    input  mips_pkg::word_t    ram_rdata,
    output mips_pkg::word_t    ram_wdata,
    output mips_pkg::byte_en_t ram_byte_en,
    output mips_pkg::word_t    load_data,
    output logic               load_en,
    output mips_pkg::reg_idx_t dest_reg,
    output logic               addr_error_load,
    output logic               addr_error_store
);

    mips_pkg::opcode_t op;
    mips_pkg::access_e size;
    logic              is_load;
    logic              is_store;
    logic              is_signed;
    logic [1:0]        offset;      // Byte offset in word
    logic              misaligned;
    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;

    assign op       = instr[31:26];
    assign offset   = addr[1:0];
    assign dest_reg = instr[20:16];  // rt

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        size      = mips_pkg::acc_none;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        case (op)
            `EXE_LB, `EXE_LBU: begin
                size      = mips_pkg::acc_byte;
                is_load   = 1'b1;
                is_signed = (op == `EXE_LB);
            end
            `EXE_LH, `EXE_LHU: begin
                size      = mips_pkg::acc_half;
                is_load   = 1'b1;
                is_signed = (op == `EXE_LH);
            end
            `EXE_LW: begin
                size    = mips_pkg::acc_word;
                is_load = 1'b1;
            end
            `EXE_SB: begin
                size     = mips_pkg::acc_byte;
                is_store = 1'b1;
            end
            `EXE_SH: begin
                size     = mips_pkg::acc_half;
                is_store = 1'b1;
            end
            `EXE_SW: begin
                size     = mips_pkg::acc_word;
                is_store = 1'b1;
            end
            default: ;  // Not a memory op
        endcase
    end

    // Halfwords on even bytes, words on word boundaries
    always_comb begin
        case (size)
            mips_pkg::acc_half: misaligned = offset[0];
            mips_pkg::acc_word: misaligned = (offset != 2'b00);
            default:            misaligned = 1'b0;
        endcase
    end

    assign addr_error_load  = is_load & misaligned;
    assign addr_error_store = is_store & misaligned;
    assign load_en          = is_load & ~misaligned;

    //////////////////////////////////////////////////
    // Store lanes
    //////////////////////////////////////////////////

    always_comb begin
        ram_byte_en = 4'b0000;
        ram_wdata   = store_data;
        case (size)
            mips_pkg::acc_byte: begin
                ram_byte_en = 4'b0001 << offset;
                ram_wdata   = {4{store_data[7:0]}};
            end
            mips_pkg::acc_half: begin
                ram_byte_en = offset[1] ? 4'b1100 : 4'b0011;
                ram_wdata   = {2{store_data[15:0]}};
            end
            mips_pkg::acc_word: ram_byte_en = 4'b1111;
            default:            ram_byte_en = 4'b0000;
        endcase
        if (!is_store || misaligned)
            ram_byte_en = 4'b0000;  // No write on loads or errors
    end

    //////////////////////////////////////////////////
    // Load select and extend
    //////////////////////////////////////////////////

    always_comb begin
        case (offset)
            2'd0:    sel_byte = ram_rdata[7:0];
            2'd1:    sel_byte = ram_rdata[15:8];
            2'd2:    sel_byte = ram_rdata[23:16];
            default: sel_byte = ram_rdata[31:24];
        endcase
        sel_half = offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];

        case (size)
            mips_pkg::acc_byte: load_data = {{24{is_signed & sel_byte[7]}}, sel_byte};
            mips_pkg::acc_half: load_data = {{16{is_signed & sel_half[15]}}, sel_half};
            mips_pkg::acc_word: load_data = ram_rdata;
            default:            load_data = '0;
        endcase
        if (!is_load)
            load_data = '0;
    end

    // Raw opcode classes, loads 100xxx and stores 101xxx, size in op[1:0]
    always_comb begin
        assert final (!(addr_error_load && addr_error_store)
                      && (!addr_error_load || op[5:3] == 3'b100)
                      && (!addr_error_store || op[5:3] == 3'b101))
            else $error("mem_ctrl: address error flags %b%b for opcode %b",
                        addr_error_load, addr_error_store, op);
        assert final (ram_byte_en == 4'b0000
                      || (op[5:3] == 3'b101 && ram_byte_en[offset]
                          && ((op[1:0] == 2'b00 && size == mips_pkg::acc_byte
                               && $countones(ram_byte_en) == 1)
                           || (op[1:0] == 2'b01 && size == mips_pkg::acc_half
                               && !offset[0] && $countones(ram_byte_en) == 2)
                           || (op[1:0] == 2'b11 && size == mips_pkg::acc_word
                               && offset == 2'b00 && ram_byte_en == 4'b1111))))
            else $error("mem_ctrl: byte enables %b for non-aligned or non-store access",
                        ram_byte_en);
    end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module data_ram (
    input  logic                clk,
    input  logic                mem_valid,
    input  mips_pkg::ram_addr_t word_addr,
    input  mips_pkg::byte_en_t  byte_en,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rdata
);

    mips_pkg::word_t mem [0:`RAM_DEPTH-1];

    //////////////////////////////////////////////////
    // Byte-lane write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            if (byte_en[0])
                mem[word_addr][7:0] <= wdata[7:0];
            if (byte_en[1])
                mem[word_addr][15:8] <= wdata[15:8];
            if (byte_en[2])
                mem[word_addr][23:16] <= wdata[23:16];
            if (byte_en[3])
                mem[word_addr][31:24] <= wdata[31:24];
        end
    end

    // Async read, whole word
    assign rdata = mem[word_addr];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // An X lane enable would corrupt memory silently
    byte_en_known_a : assert property (
        @(posedge clk) mem_valid |-> !$isunknown(byte_en)
    ) else $error("data_ram: unknown byte enables %b", byte_en);

endmodule

`default_nettype wire

// File: hdl/mem_except.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mem_except (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  mips_pkg::word_t     addr,
    input  logic                addr_error_load,
    input  logic                addr_error_store,
    output logic                except_valid,
    output mips_pkg::word_t     bad_vaddr,
    output mips_pkg::exccode_t  exc_code
);

    logic take_exc;

    assign take_exc = mem_valid & (addr_error_load | addr_error_store);

    // One-cycle pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            except_valid <= 1'b0;
        end else begin
            except_valid <= take_exc;
        end
    end

    //////////////////////////////////////////////////
    // BadVAddr and cause, held until next exception
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bad_vaddr <= '0;
            exc_code  <= '0;
        end else if (take_exc) begin
            bad_vaddr <= addr;
            exc_code  <= addr_error_load ? `EXC_ADEL : `EXC_ADES;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_valid,
    input  logic               load_en,
    input  mips_pkg::reg_idx_t dest_reg,
    input  mips_pkg::word_t    load_data,
    output logic               wb_valid,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data
);

    logic do_wb;

    // $zero is never written
    assign do_wb = mem_valid & load_en & (dest_reg != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= do_wb;
        end
    end

    //////////////////////////////////////////////////
    // Payload, stable between loads
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg  <= '0;
            wb_data <= '0;
        end else if (do_wb) begin
            wb_reg  <= dest_reg;
            wb_data <= load_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_valid,
    input  mips_pkg::word_t    instr,
    input  mips_pkg::word_t    addr,
    input  mips_pkg::word_t    store_data,
    output logic               wb_valid,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               except_valid,
    output mips_pkg::word_t    bad_vaddr,
    output mips_pkg::exccode_t exc_code
);

    mips_pkg::word_t    ram_rdata;
    mips_pkg::word_t    ram_wdata;
    mips_pkg::byte_en_t ram_byte_en;
    mips_pkg::word_t    load_data;
    logic               load_en;
    mips_pkg::reg_idx_t dest_reg;
    logic               addr_error_load;
    logic               addr_error_store;

    //////////////////////////////////////////////////
    // Alignment and lane control
    //////////////////////////////////////////////////

    mem_ctrl ctrl_i (
        .instr            (instr),
        .addr             (addr),
        .store_data       (store_data),
        .ram_rdata        (ram_rdata),
        .ram_wdata        (ram_wdata),
        .ram_byte_en      (ram_byte_en),
        .load_data        (load_data),
        .load_en          (load_en),
        .dest_reg         (dest_reg),
        .addr_error_load  (addr_error_load),
        .addr_error_store (addr_error_store)
    );

    data_ram ram_i (
        .clk       (clk),
        .mem_valid (mem_valid),
        .word_addr (addr[`RAM_AW+1:2]),  // Word index
        .byte_en   (ram_byte_en),
        .wdata     (ram_wdata),
        .rdata     (ram_rdata)
    );

    //////////////////////////////////////////////////
    // Registered outputs
    //////////////////////////////////////////////////

    mem_except except_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_valid        (mem_valid),
        .addr             (addr),
        .addr_error_load  (addr_error_load),
        .addr_error_store (addr_error_store),
        .except_valid     (except_valid),
        .bad_vaddr        (bad_vaddr),
        .exc_code         (exc_code)
    );

    mem_wb_reg wb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .load_en   (load_en),
        .dest_reg  (dest_reg),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    // A faulting access must never reach write-back
    no_wb_on_exc_a : assert property (
        @(posedge clk) disable iff (!rst_n) !(except_valid && wb_valid)
    ) else $error("mem_stage: write-back and exception in the same cycle");

endmodule

`default_nettype wire

// File: tb/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

    localparam int MAX_ROWS = 64;
    localparam int COLS     = 6;   // instr, addr, store_data, reg, data, exc
    localparam int MAX_GAP  = 3;   // Idle cycles between instructions
    localparam logic [31:0] SEED = 32'hd558;

    logic               clk;
    logic               rst_n;
    logic               mem_valid;
    mips_pkg::word_t    instr;
    mips_pkg::word_t    addr;
    mips_pkg::word_t    store_data;
    logic               wb_valid;
    mips_pkg::reg_idx_t wb_reg;
    mips_pkg::word_t    wb_data;
    logic               except_valid;
    mips_pkg::word_t    bad_vaddr;
    mips_pkg::exccode_t exc_code;

    mips_pkg::word_t stim [0:MAX_ROWS*COLS-1];

    int row_count;
    int row;
    int gap;
    int cur_row;
    int prev_row;
    logic prev_valid;
    int rows_checked = 0;
    int error_count  = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    mem_stage dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .instr        (instr),
        .addr         (addr),
        .store_data   (store_data),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .except_valid (except_valid),
        .bad_vaddr    (bad_vaddr),
        .exc_code     (exc_code)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_idx_t got,
                             input mips_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_exc(input string name, input mips_pkg::exccode_t got,
                             input mips_pkg::exccode_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            if (exp)
                $display("At %0t the %s pulse is missing", $time, name);
            else
                $display("At %0t an unexpected %s pulse was seen", $time, name);
            error_count++;
        end
    endtask

    // Results of the instruction that was in MEM one cycle earlier
    task automatic check_outputs(input logic valid, input int r);
        mips_pkg::reg_idx_t exp_reg;
        mips_pkg::word_t    exp_data;
        mips_pkg::exccode_t exp_exc;
        exp_reg  = stim[r*COLS+3][4:0];
        exp_data = stim[r*COLS+4];
        exp_exc  = stim[r*COLS+5][4:0];
        if (!valid) begin
            check_pulse("wb_valid", wb_valid, 1'b0);
            check_pulse("except_valid", except_valid, 1'b0);
        end else begin
            rows_checked++;
            check_pulse("wb_valid", wb_valid, exp_reg != 5'd0);
            if (wb_valid && exp_reg != 5'd0) begin
                check_reg("wb_reg", wb_reg, exp_reg);
                check_word("wb_data", wb_data, exp_data);
            end
            check_pulse("except_valid", except_valid, exp_exc != 5'd0);
            if (except_valid && exp_exc != 5'd0) begin
                check_exc("exc_code", exc_code, exp_exc);
                check_word("bad_vaddr", bad_vaddr, stim[r*COLS+1]);
            end
        end
    endtask

    // Sample away from the driving edge
    always @(negedge clk) begin
        if (rst_n)
            check_outputs(prev_valid, prev_row);
        prev_valid = mem_valid;
        prev_row   = cur_row;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        rst_n      <= 1'b0;
        mem_valid  <= 1'b0;
        instr      <= '0;
        addr       <= '0;
        store_data <= '0;
        cur_row    <= 0;
        prev_valid = 1'b0;
        prev_row   = 0;
        void'($urandom(SEED));

        for (row = 0; row < MAX_ROWS*COLS; row++)
            stim[row] = '1;  // All ones marks the end of the table
        $readmemh("tb/mem_stim.txt", stim);
        row_count = 0;
        while (row_count < MAX_ROWS && stim[row_count*COLS] != '1)
            row_count++;
        if (row_count == 0) begin
            $display("No instructions were read from the stimulus file");
            error_count++;
        end
        cycle_limit = row_count * (MAX_GAP + 2) + 50;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("wb_data", wb_data, '0);
        check_word("bad_vaddr", bad_vaddr, '0);

        for (row = 0; row < row_count; row++) begin
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk);
                mem_valid <= 1'b0;
            end
            @(posedge clk);
            mem_valid  <= 1'b1;
            instr      <= stim[row*COLS];
            addr       <= stim[row*COLS+1];
            store_data <= stim[row*COLS+2];
            cur_row    <= row;
        end
        @(posedge clk);
        mem_valid <= 1'b0;
        repeat (3) @(posedge clk);

        if (rows_checked != row_count) begin
            $display("Only %0d of %0d instructions produced a checked result",
                     rows_checked, row_count);
            error_count++;
        end
        $display("Checked %0d instructions, %0d errors", rows_checked, error_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_stim.txt
// instr addr store_data exp_reg exp_data exp_exc
// exp_reg 00 means no write-back, exp_exc 00 means no exception
// sw then lw of the same word
AC010000 00000100 12345678 00 00000000 00
8C020000 00000100 00000000 02 12345678 00
// sb to each lane over a known word
AC010000 00000104 AABBCCDD 00 00000000 00
A0010000 00000104 00000011 00 00000000 00
8C030000 00000104 00000000 03 AABBCC11 00
A0010000 00000105 FFFFFF22 00 00000000 00
8C030000 00000104 00000000 03 AABB2211 00
A0010000 00000106 00000033 00 00000000 00
8C030000 00000104 00000000 03 AA332211 00
A0010000 00000107 00000044 00 00000000 00
8C030000 00000104 00000000 03 44332211 00
// lb and lbu at all offsets, lh and lhu at 0 and 2
AC010000 00000108 80FF7F01 00 00000000 00
80040000 00000108 00000000 04 00000001 00
80040000 00000109 00000000 04 0000007F 00
80040000 0000010A 00000000 04 FFFFFFFF 00
80040000 0000010B 00000000 04 FFFFFF80 00
90050000 00000108 00000000 05 00000001 00
90050000 00000109 00000000 05 0000007F 00
90050000 0000010A 00000000 05 000000FF 00
90050000 0000010B 00000000 05 00000080 00
84060000 00000108 00000000 06 00007F01 00
84060000 0000010A 00000000 06 FFFF80FF 00
94070000 00000108 00000000 07 00007F01 00
94070000 0000010A 00000000 07 000080FF 00
// Misaligned loads raise AdEL
8C080000 00000101 00000000 00 00000000 04
8C080000 00000102 00000000 00 00000000 04
8C080000 00000103 00000000 00 00000000 04
84080000 00000109 00000000 00 00000000 04
84080000 0000010B 00000000 00 00000000 04
94080000 00000109 00000000 00 00000000 04
// Misaligned stores raise AdES and leave memory alone
AC010000 00000101 DEADBEEF 00 00000000 05
A4010000 00000103 0000BEEF 00 00000000 05
8C020000 00000100 00000000 02 12345678 00
// Aligned sh to the upper half
A4010000 00000106 00005566 00 00000000 00
8C030000 00000104 00000000 03 55662211 00
// Load into r0 is dropped
8C000000 00000100 00000000 00 00000000 00
8C090000 00000100 00000000 09 12345678 00

// File: compile.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/mem_ctrl.sv
hdl/data_ram.sv
hdl/mem_except.sv
hdl/mem_wb_reg.sv
hdl/mem_stage.sv
tb/mem_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator

set -u

BUILD_DIR=obj_dir
SIM_BIN=mem_stage_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module mem_stage_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

echo "Simulation finished, log in $LOG"
exit 0
